//--- filelist.f
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int    num_tests      = 4;
  localparam int    insns_per_test = 500;
  localparam int    cycle_limit    = num_tests * 520;
  localparam word_t nop_insn       = 32'h0000_0013;

  logic     clk;
  logic     rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     illegal;
  logic     wb_en;
  reg_idx_t wb_addr;
  word_t    wb_data;
  int       check_count;
  int       error_count;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          tests_passed;
  int          tests_failed;

  rv_core u_dut (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .illegal (illegal),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  rv_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .insn        (insn),
    .pc          (pc),
    .halt        (halt),
    .illegal     (illegal),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic string test_name(input int test_id);
    case (test_id)
      0: return "alu";
      1: return "control flow";
      2: return "x0 and illegal";
      default: return "mixed";
    endcase
  endfunction

  // kind 0 is reg-reg, 1 reg-imm, 2 lui, 3 auipc, 4 branch, 5 jal, 6 jalr, 7 illegal
  task automatic make_insn(input int test_id, output word_t word);
    logic [31:0] k;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [31:0] r;
    logic [11:0] imm12;
    logic [2:0]  br_f3;
    word_t       off;
    int          kind;
    take_bits(3, k);
    case (test_id)
      0: kind = k[1:0];
      1: kind = (k[2:0] == 3'd7) ? 4 : k[2:0];
      2: kind = k[2] ? 7 : k[1:0];
      default: kind = k[2:0];
    endcase
    take_bits(5, rd);
    take_bits(5, rs1);
    take_bits(5, rs2);
    take_bits(3, f3);
    take_bits(1, alt);
    take_bits(1, r);
    if (test_id == 2 && r[0]) begin
      rd = '0;
    end
    // small word aligned offset from -64 to +60
    take_bits(5, r);
    off = {{25{r[4]}}, r[4:0], 2'b00};
    br_f3 = (f3[2:1] == 2'b01) ? (f3[2:0] | 3'b100) : f3[2:0];
    case (kind)
      0: word = {(alt[0] && (f3[2:0] == 3'd0 || f3[2:0] == 3'd5)) ? funct7_alt : 7'd0,
                 rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg_reg};
      1: begin
        take_bits(12, r);
        imm12 = r[11:0];
        if (f3[2:0] == 3'd1) begin
          imm12[11:5] = 7'd0;
        end else if (f3[2:0] == 3'd5) begin
          imm12[11:5] = alt[0] ? funct7_alt : 7'd0;
        end
        word = {imm12, rs1[4:0], f3[2:0], rd[4:0], op_reg_imm};
      end
      2, 3: begin
        take_bits(20, r);
        word = {r[19:0], rd[4:0], (kind == 2) ? op_lui : op_auipc};
      end
      4: word = {off[12], off[10:5], rs2[4:0], rs1[4:0], br_f3, off[4:1], off[11], op_branch};
      5: word = {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
      // base x0 keeps the jalr target aligned once bit 0 is dropped
      6: word = {4'b0, rs2[4:0], alt[0], 1'b0, f3[0], 5'd0, 3'b000, rd[4:0], op_jalr};
      default: begin
        take_bits(25, r);
        case (f3[1:0])
          2'd0: word = {r[24:0], 7'b000_0011};
          2'd1: word = {7'h01, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg_reg};
          2'd2: word = 32'h0010_0073;
          default: word = {r[24:8], 3'b010, r[4:0], op_branch};
        endcase
      end
    endcase
  endtask

  task automatic run_test(input int test_id);
    word_t word;
    @(posedge clk);
    rst  <= 1'b1;
    insn <= nop_insn;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < insns_per_test; n++) begin
      make_insn(test_id, word);
      insn <= word;
      @(posedge clk);
    end
    insn <= ecall_insn;
    do begin
      @(posedge clk);
    end while (!halt);
    // pc must stay parked while ecall is held
    repeat (3) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    int errors_before;
    int checks_before;
    rst          = 1'b1;
    insn         = nop_insn;
    lfsr_state   = 32'h3419b87a;
    cycle_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int t = 0; t < num_tests; t++) begin
      errors_before = error_count;
      checks_before = check_count;
      run_test(t);
      @(negedge clk);
      if (error_count == errors_before) begin
        tests_passed++;
      end else begin
        tests_failed++;
      end
      $display("test %0d %s: %0d checks, %0d errors", t, test_name(t),
               check_count - checks_before, error_count - errors_before);
    end
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, check_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  input  rv_pkg::word_t    pc,
  input  logic             halt,
  input  logic             illegal,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_addr,
  input  rv_pkg::word_t    wb_data,
  output int               check_count,
  output int               error_count
);
  import rv_pkg::*;

  // architectural state of the reference model
  word_t model_regs [0:31];
  word_t model_pc;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  task automatic compare_value(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error %s: expected %h, actual %h (pc %h, insn %h)",
               name, expected, actual, model_pc, insn);
    end
  endtask

  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  // one instruction against the model state, no state change here
  task automatic evaluate(input word_t i, output logic exp_illegal, output logic exp_halt,
                          output logic exp_wb_en, output word_t exp_wb_data,
                          output word_t exp_next_pc);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      target;
    logic       writes;
    logic       jump;
    logic       alt;
    op    = i[6:0];
    f3    = i[14:12];
    f7    = i[31:25];
    a     = model_regs[i[19:15]];
    b     = model_regs[i[24:20]];
    imm_i = word_t'($signed(i) >>> 20);
    imm_u = i & 32'hffff_f000;
    imm_b = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    exp_illegal = 1'b0;
    exp_halt    = 1'b0;
    exp_wb_data = '0;
    writes      = 1'b0;
    jump        = 1'b0;
    target      = '0;
    alt         = (f7 == funct7_alt);
    case (op)
      op_lui: begin
        writes      = 1'b1;
        exp_wb_data = imm_u;
      end
      op_auipc: begin
        writes      = 1'b1;
        exp_wb_data = model_pc + imm_u;
      end
      op_jal: begin
        writes      = 1'b1;
        exp_wb_data = model_pc + 32'd4;
        jump        = 1'b1;
        target      = model_pc + imm_j;
      end
      op_jalr: begin
        writes      = (f3 == 3'd0);
        exp_illegal = (f3 != 3'd0);
        exp_wb_data = model_pc + 32'd4;
        jump        = 1'b1;
        target      = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        exp_illegal = (f3 == 3'd2) || (f3 == 3'd3);
        jump        = branch_model(f3, a, b);
        target      = model_pc + imm_b;
      end
      op_reg_imm: begin
        // shifts take shamt from the immediate, upper bits pick the kind
        if (f3 == 3'd1) begin
          exp_illegal = (f7 != 7'd0);
          alt         = 1'b0;
        end else if (f3 == 3'd5) begin
          exp_illegal = (f7 != 7'd0) && !alt;
        end else begin
          alt = 1'b0;
        end
        writes      = 1'b1;
        exp_wb_data = alu_model(f3, alt, a, imm_i);
      end
      op_reg_reg: begin
        exp_illegal = !(f7 == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        writes      = 1'b1;
        exp_wb_data = alu_model(f3, alt, a, b);
      end
      op_system: begin
        exp_halt    = (i == ecall_insn);
        exp_illegal = (i != ecall_insn);
      end
      default: exp_illegal = 1'b1;
    endcase
    exp_wb_en = writes && !exp_illegal && (i[11:7] != 5'd0);
    if (exp_halt) begin
      exp_next_pc = model_pc;
    end else if (jump && !exp_illegal) begin
      exp_next_pc = target;
    end else begin
      exp_next_pc = model_pc + 32'd4;
    end
  endtask

  always @(posedge clk) begin
    logic  exp_illegal;
    logic  exp_halt;
    logic  exp_wb_en;
    word_t exp_wb_data;
    word_t exp_next_pc;
    if (rst) begin
      compare_value("wb_en", '0, word_t'(wb_en));
      model_pc = '0;
      for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
      end
    end else begin
      evaluate(insn, exp_illegal, exp_halt, exp_wb_en, exp_wb_data, exp_next_pc);
      compare_value("pc", model_pc, pc);
      compare_value("illegal", word_t'(exp_illegal), word_t'(illegal));
      compare_value("halt", word_t'(exp_halt), word_t'(halt));
      compare_value("wb_en", word_t'(exp_wb_en), word_t'(wb_en));
      if (exp_wb_en) begin
        compare_value("wb_addr", word_t'(insn[11:7]), word_t'(wb_addr));
        compare_value("wb_data", exp_wb_data, wb_data);
        model_regs[insn[11:7]] = exp_wb_data;
      end
      model_pc = exp_next_pc;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  output rv_pkg::word_t    pc,
  output logic             halt,
  output logic             illegal,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_addr,
  output rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  // decode outputs
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  word_t    imm;
  alu_op_e  alu_op;
  logic     use_imm;
  br_cond_e br_cond;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  wb_sel_e  wb_sel;
  logic     is_ecall;

  // register reads and execute results
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  br_taken;
  word_t jump_target;

  rv_decode u_decode (
    .insn      (insn),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .br_cond   (br_cond),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .wb_sel    (wb_sel),
    .is_ecall  (is_ecall),
    .illegal   (illegal)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  rv_execute u_execute (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .br_cond     (br_cond),
    .is_jalr     (is_jalr),
    .alu_result  (alu_result),
    .br_taken    (br_taken),
    .jump_target (jump_target)
  );

  rv_result u_result (
    .clk         (clk),
    .rst         (rst),
    .rd_idx      (rd_idx),
    .imm         (imm),
    .wb_sel      (wb_sel),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_ecall    (is_ecall),
    .illegal     (illegal),
    .alu_result  (alu_result),
    .br_taken    (br_taken),
    .jump_target (jump_target),
    .pc          (pc),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .halt        (halt)
  );

endmodule

`default_nettype wire

//--- logic/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rd_idx,
  input  rv_pkg::word_t    imm,
  input  rv_pkg::wb_sel_e  wb_sel,
  input  logic             is_branch,
  input  logic             is_jal,
  input  logic             is_jalr,
  input  logic             is_ecall,
  input  logic             illegal,
  input  rv_pkg::word_t    alu_result,
  input  logic             br_taken,
  input  rv_pkg::word_t    jump_target,
  output rv_pkg::word_t    pc,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_addr,
  output rv_pkg::word_t    wb_data,
  output logic             halt
);
  import rv_pkg::*;

  word_t pc_plus4;
  word_t pc_next;
  logic  redirect;

  assign pc_plus4 = pc + insn_bytes;
  assign redirect = is_jal || is_jalr || (is_branch && br_taken);

  // ecall parks the pc, illegal just falls through
  always_comb begin
    if (is_ecall) begin
      pc_next = pc;
    end else if (!illegal && redirect) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  always_comb begin
    case (wb_sel)
      wb_alu:      wb_data = alu_result;
      wb_imm:      wb_data = imm;
      wb_pc_plus4: wb_data = pc_plus4;
      wb_pc_imm:   wb_data = pc + imm;
      default:     wb_data = '0;
    endcase
  end

  // decode already forces wb_none on illegal and ecall
  assign wb_en   = !rst && wb_sel != wb_none && rd_idx != '0;
  assign wb_addr = rd_idx;
  assign halt    = is_ecall;

  // targets come from execute, the fetch side needs word alignment
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    imm,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::alu_op_e  alu_op,
  input  logic             use_imm,
  input  rv_pkg::br_cond_e br_cond,
  input  logic             is_jalr,
  output rv_pkg::word_t    alu_result,
  output logic             br_taken,
  output rv_pkg::word_t    jump_target
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  word_t      jalr_sum;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // shared by slt/sltu and the branches
  assign lt_s = $signed(rs1_data) < $signed(op_b);
  assign lt_u = rs1_data < op_b;

  always_comb begin
    case (alu_op)
      alu_add:  alu_result = rs1_data + op_b;
      alu_sub:  alu_result = rs1_data - op_b;
      alu_sll:  alu_result = rs1_data << shamt;
      alu_slt:  alu_result = {31'b0, lt_s};
      alu_sltu: alu_result = {31'b0, lt_u};
      alu_xor:  alu_result = rs1_data ^ op_b;
      alu_srl:  alu_result = rs1_data >> shamt;
      alu_sra:  alu_result = word_t'($signed(rs1_data) >>> shamt);
      alu_or:   alu_result = rs1_data | op_b;
      alu_and:  alu_result = rs1_data & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branches never set use_imm, so op_b is rs2 here
  always_comb begin
    case (br_cond)
      br_eq:   br_taken = (rs1_data == op_b);
      br_ne:   br_taken = (rs1_data != op_b);
      br_lt:   br_taken = lt_s;
      br_ge:   br_taken = !lt_s;
      br_ltu:  br_taken = lt_u;
      br_geu:  br_taken = !lt_u;
      default: br_taken = 1'b0;
    endcase
  end

  // jalr is register relative with bit 0 dropped
  assign jalr_sum    = rs1_data + imm;
  assign jump_target = is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_addr,
  input  rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational reads
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // writeback stage must filter rd == x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst) wb_en |-> wb_addr != '0
  );

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::reg_idx_t rd_idx,
  output rv_pkg::word_t    imm,
  output rv_pkg::alu_op_e  alu_op,
  output logic             use_imm,
  output rv_pkg::br_cond_e br_cond,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output rv_pkg::wb_sel_e  wb_sel,
  output logic             is_ecall,
  output logic             illegal
);
  import rv_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;
  alu_op_e base_op;
  logic    alt_ok;

  assign opcode  = insn[6:0];
  assign rd_idx  = insn[11:7];
  assign funct3  = insn[14:12];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];
  assign funct7  = insn[31:25];

  // immediates sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // alu op for funct7 base
  always_comb begin
    case (funct3)
      f3_add:  base_op = alu_add;
      f3_sll:  base_op = alu_sll;
      f3_slt:  base_op = alu_slt;
      f3_sltu: base_op = alu_sltu;
      f3_xor:  base_op = alu_xor;
      f3_sr:   base_op = alu_srl;
      f3_or:   base_op = alu_or;
      default: base_op = alu_and;
    endcase
  end

  // only add and shift-right have an alt form
  assign alt_ok = (funct3 == f3_add) || (funct3 == f3_sr);

  always_comb begin
    imm       = imm_i;
    alu_op    = alu_add;
    use_imm   = 1'b0;
    br_cond   = br_eq;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    wb_sel    = wb_none;
    is_ecall  = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      op_lui: begin
        imm    = imm_u;
        wb_sel = wb_imm;
      end
      op_auipc: begin
        imm    = imm_u;
        wb_sel = wb_pc_imm;
      end
      op_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = wb_pc_plus4;
      end
      op_jalr: begin
        is_jalr = (funct3 == f3_jalr);
        illegal = (funct3 != f3_jalr);
        wb_sel  = wb_pc_plus4;
      end
      op_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          f3_beq:  br_cond = br_eq;
          f3_bne:  br_cond = br_ne;
          f3_blt:  br_cond = br_lt;
          f3_bge:  br_cond = br_ge;
          f3_bltu: br_cond = br_ltu;
          f3_bgeu: br_cond = br_geu;
          default: begin
            is_branch = 1'b0;
            illegal   = 1'b1;
          end
        endcase
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        wb_sel  = wb_alu;
        alu_op  = base_op;
        // shamt sits in imm[4:0] and funct7 still has to be legal
        if (funct3 == f3_sll || funct3 == f3_sr) begin
          if (funct7 == funct7_alt && funct3 == f3_sr) begin
            alu_op = alu_sra;
          end else if (funct7 != funct7_base) begin
            illegal = 1'b1;
          end
        end
      end
      op_reg_reg: begin
        wb_sel = wb_alu;
        if (funct7 == funct7_base) begin
          alu_op = base_op;
        end else if (funct7 == funct7_alt && alt_ok) begin
          alu_op = (funct3 == f3_add) ? alu_sub : alu_sra;
        end else begin
          illegal = 1'b1;
        end
      end
      op_system: begin
        is_ecall = (insn == ecall_insn);
        illegal  = (insn != ecall_insn);
      end
      default: illegal = 1'b1;
    endcase
    // an illegal encoding writes nothing
    if (illegal) begin
      wb_sel = wb_none;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  // vectors with a meaning of their own
  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // major opcodes
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_jalr    = 7'b11_001_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_system  = 7'b11_100_11;

  // funct3 for the alu groups
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct3 for branches and jalr
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;
  localparam funct3_t f3_jalr = 3'b000;

  // funct7, alt selects sub and sra
  localparam funct7_t funct7_base = 7'b000_0000;
  localparam funct7_t funct7_alt  = 7'b010_0000;

  localparam word_t insn_bytes = 32'd4;
  localparam word_t ecall_insn = 32'h0000_0073;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // values follow the branch funct3 encoding
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  typedef enum logic [2:0] {
    wb_none,
    wb_alu,
    wb_imm,
    wb_pc_plus4,
    wb_pc_imm
  } wb_sel_e;

endpackage

`default_nettype wire
